/* hdl/kbd_pkg.sv */
package kbd_pkg;

    // key code is {extend flag, scan byte}
    localparam int KEY_W = 9;

    typedef logic [KEY_W-1:0] key_code_t;

    localparam logic [7:0] SC_INIT   = 8'hAA; // keyboard self-test passed
    localparam logic [7:0] SC_EXTEND = 8'hE0;
    localparam logic [7:0] SC_BREAK  = 8'hF0;

    typedef enum logic [1:0] {
        WAIT_INIT, // nothing decoded before the self-test byte
        IDLE,
        ACK_HIGH
    } dec_state_e;

endpackage

/* hdl/audio_pkg.sv */
package audio_pkg;

    localparam int SAMPLE_W = 16;

    typedef logic signed [SAMPLE_W-1:0] sample_t;

    typedef enum logic {
        REG_VOLUME = 1'b0,
        REG_CTRL   = 1'b1
    } reg_addr_e;

    // bit positions inside REG_CTRL
    localparam int CTRL_MUTE_BIT = 0;
    localparam int CTRL_OCT_LO   = 1;
    localparam int CTRL_OCT_HI   = 2;

    localparam int N_NOTES = 8; // A S D F G H J K

endpackage

/* hdl/scan_decoder.sv */
module scan_decoder (
    input  logic               clk,
    input  logic               rst,
    input  logic               scan_req_i,
    input  logic [7:0]         scan_data_i,
    output logic               scan_ack_o,
    output logic               key_valid_o,
    output kbd_pkg::key_code_t key_code_o,
    output logic               key_break_o
);

    kbd_pkg::dec_state_e state;
    logic extend_q;
    logic break_q;
    logic accept;
    logic is_extend;
    logic is_break;
    logic emit;

    assign accept    = scan_req_i && !scan_ack_o; // new byte on the port
    assign is_extend = (scan_data_i == kbd_pkg::SC_EXTEND);
    assign is_break  = (scan_data_i == kbd_pkg::SC_BREAK);
    assign emit      = accept && (state == kbd_pkg::IDLE) && !is_extend && !is_break;

    // ack follows req one cycle late, in every state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scan_ack_o <= 1'b0;
        end else if (accept) begin
            scan_ack_o <= 1'b1;
        end else if (!scan_req_i) begin
            scan_ack_o <= 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= kbd_pkg::WAIT_INIT;
            extend_q    <= 1'b0;
            break_q     <= 1'b0;
            key_valid_o <= 1'b0;
        end else begin
            key_valid_o <= emit;
            case (state)
                kbd_pkg::WAIT_INIT: begin
                    if (accept && scan_data_i == kbd_pkg::SC_INIT) begin
                        state <= kbd_pkg::ACK_HIGH;
                    end
                end
                kbd_pkg::IDLE: begin
                    if (accept) begin
                        state <= kbd_pkg::ACK_HIGH;
                        if (is_extend) begin
                            extend_q <= 1'b1;
                        end else if (is_break) begin
                            break_q <= 1'b1;
                        end else begin
                            extend_q <= 1'b0; // prefixes apply to one code only
                            break_q  <= 1'b0;
                        end
                    end
                end
                kbd_pkg::ACK_HIGH: begin
                    if (!scan_req_i) begin
                        state <= kbd_pkg::IDLE;
                    end
                end
                default: begin
                    state <= kbd_pkg::WAIT_INIT;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            key_code_o  <= {extend_q, scan_data_i};
            key_break_o <= break_q;
        end
    end

    a_ack_after_req: assert property (
        @(posedge clk) disable iff (rst)
        $rose(scan_ack_o) |-> $past(scan_req_i)
    );

endmodule

/* hdl/tone_regs.sv */
module tone_regs (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            cfg_req_i,
    input  logic                            cfg_we_i,
    input  audio_pkg::reg_addr_e            cfg_addr_i,
    input  logic [audio_pkg::SAMPLE_W-1:0]  cfg_wdata_i,
    output logic [audio_pkg::SAMPLE_W-1:0]  cfg_rdata_o,
    output logic                            cfg_ack_o,
    output logic [audio_pkg::SAMPLE_W-1:0]  volume_o,
    output logic                            mute_o,
    output logic [1:0]                      octave_o
);

    logic                           accept;
    logic [audio_pkg::SAMPLE_W-1:0] ctrl_word;

    assign accept = cfg_req_i && !cfg_ack_o;

    always_comb begin
        ctrl_word = '0;
        ctrl_word[audio_pkg::CTRL_MUTE_BIT] = mute_o;
        ctrl_word[audio_pkg::CTRL_OCT_HI:audio_pkg::CTRL_OCT_LO] = octave_o;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg_ack_o <= 1'b0;
            volume_o  <= '0;
            mute_o    <= 1'b1; // silent until the host says otherwise
            octave_o  <= 2'd0;
        end else begin
            if (accept) begin
                cfg_ack_o <= 1'b1;
            end else if (!cfg_req_i) begin
                cfg_ack_o <= 1'b0;
            end
            if (accept && cfg_we_i) begin
                if (cfg_addr_i == audio_pkg::REG_VOLUME) begin
                    volume_o <= cfg_wdata_i;
                end else begin
                    mute_o   <= cfg_wdata_i[audio_pkg::CTRL_MUTE_BIT];
                    octave_o <= cfg_wdata_i[audio_pkg::CTRL_OCT_HI:audio_pkg::CTRL_OCT_LO];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cfg_rdata_o <= (cfg_addr_i == audio_pkg::REG_CTRL) ? ctrl_word : volume_o;
        end
    end

    a_ack_after_req: assert property (
        @(posedge clk) disable iff (rst)
        $rose(cfg_ack_o) |-> $past(cfg_req_i)
    );

endmodule

/* hdl/tone_gen.sv */
module tone_gen (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           key_valid_i,
    input  kbd_pkg::key_code_t             key_code_i,
    input  logic                           key_break_i,
    input  logic [audio_pkg::SAMPLE_W-1:0] volume_i,
    input  logic                           mute_i,
    input  logic [1:0]                     octave_i,
    input  logic                           sample_tick_i,
    output audio_pkg::sample_t             sample_o
);

    localparam int IDX_W = $clog2(audio_pkg::N_NOTES);

    logic [audio_pkg::N_NOTES-1:0] held;
    logic                          note_hit;
    logic [IDX_W-1:0]              note_idx;
    logic [IDX_W-1:0]              sel_idx;
    logic                          any_held;
    logic [4:0]                    base_half;
    logic [4:0]                    half;
    logic [4:0]                    cnt;
    logic                          wave_neg;
    audio_pkg::sample_t            amp;
    logic [audio_pkg::SAMPLE_W-1:0] mag;

    // non-extended codes of the eight note keys
    always_comb begin
        note_hit = 1'b1;
        note_idx = '0;
        case (key_code_i)
            9'h01C:  note_idx = 3'd0;
            9'h01B:  note_idx = 3'd1;
            9'h023:  note_idx = 3'd2;
            9'h02B:  note_idx = 3'd3;
            9'h034:  note_idx = 3'd4;
            9'h033:  note_idx = 3'd5;
            9'h03B:  note_idx = 3'd6;
            9'h042:  note_idx = 3'd7;
            default: note_hit = 1'b0;
        endcase
    end

    always_comb begin
        sel_idx = '0;
        for (int i = audio_pkg::N_NOTES - 1; i >= 0; i--) begin
            if (held[i]) begin
                sel_idx = IDX_W'(i); // lowest index wins
            end
        end
    end

    always_comb begin
        case (sel_idx)
            3'd0:    base_half = 5'd16;
            3'd1:    base_half = 5'd14;
            3'd2:    base_half = 5'd13;
            3'd3:    base_half = 5'd12;
            3'd4:    base_half = 5'd11;
            3'd5:    base_half = 5'd10;
            3'd6:    base_half = 5'd9;
            default: base_half = 5'd8;
        endcase
    end

    assign any_held = |held;
    assign half     = base_half >> octave_i;
    assign amp      = volume_i[audio_pkg::SAMPLE_W-1] ? 16'sh7FFF : audio_pkg::sample_t'(volume_i);
    assign mag      = sample_o[audio_pkg::SAMPLE_W-1] ? -sample_o : sample_o;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            held     <= '0;
            cnt      <= 5'd0;
            wave_neg <= 1'b0;
            sample_o <= '0;
        end else begin
            if (key_valid_i && note_hit) begin
                held[note_idx] <= !key_break_i;
            end
            if (sample_tick_i) begin
                if (!any_held) begin
                    cnt      <= 5'd0;
                    wave_neg <= 1'b0;
                end else if (cnt + 5'd1 >= half) begin
                    cnt      <= 5'd0;
                    wave_neg <= !wave_neg; // half period done
                end else begin
                    cnt <= cnt + 5'd1;
                end
                if (mute_i || !any_held) begin
                    sample_o <= '0;
                end else begin
                    sample_o <= wave_neg ? -amp : amp;
                end
            end
        end
    end

    a_mag_le_volume: assert property (
        @(posedge clk) disable iff (rst)
        sample_tick_i |=> mag <= $past(volume_i)
    );

endmodule

/* hdl/i2s_serializer.sv */
module i2s_serializer #(
    parameter int BIT_LOG2 = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  audio_pkg::sample_t sample_left_i,
    input  audio_pkg::sample_t sample_right_i,
    output logic               sample_tick_o,
    output logic               lrck_o,
    output logic               sck_o,
    output logic               sdin_o
);

    localparam int FRAME_W = BIT_LOG2 + 5; // 32 slots per frame

    logic [FRAME_W-1:0] cnt;
    logic [4:0]         slot;
    logic               frame_end;
    audio_pkg::sample_t left_q;
    audio_pkg::sample_t right_q;
    logic               prev_lsb;
    logic [3:0]         left_idx;
    logic [3:0]         right_idx;

    assign slot      = cnt[FRAME_W-1:BIT_LOG2];
    assign frame_end = &cnt;

    assign sample_tick_o = (cnt == '0);
    assign lrck_o        = slot[4];
    assign sck_o         = cnt[BIT_LOG2-1]; // high in second half of slot

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt      <= '0;
            left_q   <= '0;
            right_q  <= '0;
            prev_lsb <= 1'b0;
        end else begin
            cnt <= cnt + 1'b1;
            if (frame_end) begin
                left_q   <= sample_left_i;
                right_q  <= sample_right_i;
                prev_lsb <= right_q[0]; // right LSB spills into next slot 0
            end
        end
    end

    assign left_idx  = 4'(5'd16 - slot);
    assign right_idx = 4'(6'd32 - {1'b0, slot});

    always_comb begin
        if (slot == 5'd0) begin
            sdin_o = prev_lsb;
        end else if (slot <= 5'd16) begin
            sdin_o = left_q[left_idx]; // msb first
        end else begin
            sdin_o = right_q[right_idx];
        end
    end

    a_lrck_edges: assert property (
        @(posedge clk) disable iff (rst)
        $changed(lrck_o) |-> (cnt[BIT_LOG2-1:0] == '0) && (slot[3:0] == 4'd0)
    );

endmodule

/* hdl/seg_display.sv */
module seg_display #(
    parameter int SCAN_LOG2 = 16
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               key_valid_i,
    input  kbd_pkg::key_code_t key_code_i,
    input  logic               key_break_i,
    output logic [6:0]         seg_o,
    output logic [3:0]         digit_o
);

    logic [SCAN_LOG2-1:0] scan_cnt;
    logic [1:0]           sel;
    logic [1:0]           sel_next;
    kbd_pkg::key_code_t   code_q;
    logic                 break_q;
    logic [3:0]           nib;

    assign sel_next = sel + 2'd1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scan_cnt <= '0;
            sel      <= 2'd3; // first step lands on digit 0
            digit_o  <= 4'b1111;
            code_q   <= '0;
            break_q  <= 1'b0;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
            if (&scan_cnt) begin
                sel     <= sel_next;
                digit_o <= ~(4'b0001 << sel_next);
            end
            if (key_valid_i) begin
                code_q  <= key_code_i;
                break_q <= key_break_i;
            end
        end
    end

    always_comb begin
        case (sel)
            2'd0:    nib = code_q[3:0];
            2'd1:    nib = code_q[7:4];
            default: nib = {3'b000, code_q[8]};
        endcase
    end

    always_comb begin
        if (sel == 2'd3) begin
            seg_o = break_q ? 7'b0111111 : 7'b1111111; // dash or blank
        end else begin
            case (nib)
                4'h0:    seg_o = 7'b1000000;
                4'h1:    seg_o = 7'b1111001;
                4'h2:    seg_o = 7'b0100100;
                4'h3:    seg_o = 7'b0110000;
                4'h4:    seg_o = 7'b0011001;
                4'h5:    seg_o = 7'b0010010;
                4'h6:    seg_o = 7'b0000010;
                4'h7:    seg_o = 7'b1111000;
                4'h8:    seg_o = 7'b0000000;
                4'h9:    seg_o = 7'b0010000;
                4'hA:    seg_o = 7'b0001000;
                4'hB:    seg_o = 7'b0000011;
                4'hC:    seg_o = 7'b1000110;
                4'hD:    seg_o = 7'b0100001;
                4'hE:    seg_o = 7'b0000110;
                default: seg_o = 7'b0001110;
            endcase
        end
    end

endmodule

/* hdl/key_tone_top.sv */
module key_tone_top #(
    parameter int I2S_BIT_LOG2  = 4,
    parameter int SEG_SCAN_LOG2 = 16
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           scan_req_i,
    input  logic [7:0]                     scan_data_i,
    output logic                           scan_ack_o,
    input  logic                           cfg_req_i,
    input  logic                           cfg_we_i,
    input  audio_pkg::reg_addr_e           cfg_addr_i,
    input  logic [audio_pkg::SAMPLE_W-1:0] cfg_wdata_i,
    output logic [audio_pkg::SAMPLE_W-1:0] cfg_rdata_o,
    output logic                           cfg_ack_o,
    output logic                           lrck_o,
    output logic                           sck_o,
    output logic                           sdin_o,
    output logic [6:0]                     seg_o,
    output logic [3:0]                     digit_o
);

    logic                           key_valid;
    kbd_pkg::key_code_t             key_code;
    logic                           key_break;
    logic [audio_pkg::SAMPLE_W-1:0] volume;
    logic                           mute;
    logic [1:0]                     octave;
    audio_pkg::sample_t             sample;
    logic                           sample_tick;

    scan_decoder u_scan_decoder (
        .clk(clk), .rst(rst),
        .scan_req_i(scan_req_i), .scan_data_i(scan_data_i), .scan_ack_o(scan_ack_o),
        .key_valid_o(key_valid), .key_code_o(key_code), .key_break_o(key_break)
    );

    tone_regs u_tone_regs (
        .clk(clk), .rst(rst),
        .cfg_req_i(cfg_req_i), .cfg_we_i(cfg_we_i), .cfg_addr_i(cfg_addr_i),
        .cfg_wdata_i(cfg_wdata_i), .cfg_rdata_o(cfg_rdata_o), .cfg_ack_o(cfg_ack_o),
        .volume_o(volume), .mute_o(mute), .octave_o(octave)
    );

    tone_gen u_tone_gen (
        .clk(clk), .rst(rst),
        .key_valid_i(key_valid), .key_code_i(key_code), .key_break_i(key_break),
        .volume_i(volume), .mute_i(mute), .octave_i(octave),
        .sample_tick_i(sample_tick), .sample_o(sample)
    );

    // mono source, same sample on both channels
    i2s_serializer #(.BIT_LOG2(I2S_BIT_LOG2)) u_i2s_serializer (
        .clk(clk), .rst(rst),
        .sample_left_i(sample), .sample_right_i(sample), .sample_tick_o(sample_tick),
        .lrck_o(lrck_o), .sck_o(sck_o), .sdin_o(sdin_o)
    );

    seg_display #(.SCAN_LOG2(SEG_SCAN_LOG2)) u_seg_display (
        .clk(clk), .rst(rst),
        .key_valid_i(key_valid), .key_code_i(key_code), .key_break_i(key_break),
        .seg_o(seg_o), .digit_o(digit_o)
    );

endmodule

/* bench/tb_key_tone.sv */
module tb_key_tone;

    localparam int HS_LIMIT    = 20;  // cycles per handshake phase
    localparam int FRAME_LIMIT = 300; // cycles, a frame is 128 here
    localparam int FLIP_LIMIT  = 40;  // frames
    localparam int DIGIT_LIMIT = 32;

    // active low, bit 6 is segment g
    localparam logic [6:0] SEG_5     = 7'b0010010;
    localparam logic [6:0] SEG_B     = 7'b0000011;
    localparam logic [6:0] SEG_DASH  = 7'b0111111;
    localparam logic [6:0] SEG_BLANK = 7'b1111111;

    logic                           clk;
    logic                           rst;
    logic                           scan_req_i;
    logic [7:0]                     scan_data_i;
    logic                           scan_ack_o;
    logic                           cfg_req_i;
    logic                           cfg_we_i;
    audio_pkg::reg_addr_e           cfg_addr_i;
    logic [audio_pkg::SAMPLE_W-1:0] cfg_wdata_i;
    logic [audio_pkg::SAMPLE_W-1:0] cfg_rdata_o;
    logic                           cfg_ack_o;
    logic                           lrck_o;
    logic                           sck_o;
    logic                           sdin_o;
    logic [6:0]                     seg_o;
    logic [3:0]                     digit_o;

    int          seed = 19050;
    int          errors = 0;
    int          err_mark = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    string       test_name = "";
    string       chk_name = "";
    logic        chk_en = 1'b0;
    logic [31:0] chk_exp = '0;
    logic [31:0] chk_act = '0;

    int                 ev_cnt = 0;
    kbd_pkg::key_code_t ev_code = '0;
    logic               ev_break = 1'b0;

    int                 slot_k = 0;
    logic               prev_lrck = 1'b0;
    logic               synced = 1'b0;
    logic [15:0]        left_sh = '0;
    logic [15:0]        right_sh = '0;
    int                 cap_frames = 0;
    audio_pkg::sample_t cap_left = '0;
    audio_pkg::sample_t cap_right = '0;
    audio_pkg::sample_t cap_right_left = '0; // left of the frame cap_right came from

    int half_tab [audio_pkg::N_NOTES] = '{16, 14, 13, 12, 11, 10, 9, 8};

    key_tone_top #(.I2S_BIT_LOG2(2), .SEG_SCAN_LOG2(2)) DUT (
        .clk(clk), .rst(rst),
        .scan_req_i(scan_req_i), .scan_data_i(scan_data_i), .scan_ack_o(scan_ack_o),
        .cfg_req_i(cfg_req_i), .cfg_we_i(cfg_we_i), .cfg_addr_i(cfg_addr_i),
        .cfg_wdata_i(cfg_wdata_i), .cfg_rdata_o(cfg_rdata_o), .cfg_ack_o(cfg_ack_o),
        .lrck_o(lrck_o), .sck_o(sck_o), .sdin_o(sdin_o),
        .seg_o(seg_o), .digit_o(digit_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    a_check_value: assert property (
        @(posedge clk) disable iff (rst)
        chk_en |-> chk_act == chk_exp
    ) else begin
        $display("[ERROR] %s expected %0h actual %0h", chk_name, chk_exp, chk_act);
        errors++;
    end

    a_scan_ack_hold: assert property (
        @(posedge clk) disable iff (rst)
        $fell(scan_ack_o) |-> !$past(scan_req_i)
    ) else begin
        $display("scan ack dropped while the source still held req high");
        errors++;
    end

    // key events seen on the internal decoder outputs
    always @(negedge clk) begin
        if (DUT.key_valid) begin
            ev_cnt   <= ev_cnt + 1;
            ev_code  <= DUT.key_code;
            ev_break <= DUT.key_break;
        end
    end

    // I2S capture, first rising sck after lrck falls is slot 0
    always @(posedge sck_o) begin
        if (prev_lrck && !lrck_o) begin
            if (synced) begin
                cap_right      = {right_sh[14:0], sdin_o};
                cap_right_left = cap_left;
            end
            synced = 1'b1;
            slot_k = 0;
        end else begin
            slot_k++;
        end
        prev_lrck = lrck_o;
        if (synced && slot_k >= 1 && slot_k <= 16) begin
            left_sh = {left_sh[14:0], sdin_o};
        end
        if (synced && slot_k == 16) begin
            cap_left = left_sh;
            cap_frames++;
        end
        if (synced && slot_k >= 17) begin
            right_sh = {right_sh[14:0], sdin_o};
        end
    end

    function automatic logic [15:0] magnitude(input audio_pkg::sample_t s);
        return (s < 0) ? -s : s;
    endfunction

    task automatic check_eq(input string label, input logic [31:0] exp,
                            input logic [31:0] act);
        @(negedge clk);
        chk_name = {test_name, ": ", label};
        chk_exp  = exp;
        chk_act  = act;
        chk_en   = 1'b1;
        @(negedge clk);
        chk_en = 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_mark  = errors;
        tests_run++;
    endtask

    task automatic finish_test();
        if (errors == err_mark) begin
            $display("%s: ok", test_name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", test_name, errors - err_mark);
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        int t;
        @(negedge clk);
        scan_data_i = b;
        scan_req_i  = 1'b1;
        t = 0;
        while (!scan_ack_o && t < HS_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (!scan_ack_o) begin
            $display("timeout: scan ack never rose for byte %h", b);
            errors++;
        end
        scan_req_i = 1'b0;
        t = 0;
        while (scan_ack_o && t < HS_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (scan_ack_o) begin
            $display("timeout: scan ack never fell for byte %h", b);
            errors++;
        end
    endtask

    task automatic cfg_access(input logic we, input audio_pkg::reg_addr_e addr,
                              input logic [15:0] wdata, output logic [15:0] rdata);
        int t;
        @(negedge clk);
        cfg_we_i    = we;
        cfg_addr_i  = addr;
        cfg_wdata_i = wdata;
        cfg_req_i   = 1'b1;
        t = 0;
        while (!cfg_ack_o && t < HS_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (!cfg_ack_o) begin
            $display("timeout: config ack never rose");
            errors++;
        end
        rdata     = cfg_rdata_o; // valid while ack is high
        cfg_req_i = 1'b0;
        t = 0;
        while (cfg_ack_o && t < HS_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (cfg_ack_o) begin
            $display("timeout: config ack never fell");
            errors++;
        end
    endtask

    task automatic cfg_write(input audio_pkg::reg_addr_e addr, input logic [15:0] wdata);
        logic [15:0] unused;
        cfg_access(1'b1, addr, wdata, unused);
    endtask

    task automatic cfg_read(input audio_pkg::reg_addr_e addr, output logic [15:0] rdata);
        cfg_access(1'b0, addr, 16'h0000, rdata);
    endtask

    task automatic wait_frame();
        int t;
        int start;
        start = cap_frames;
        t = 0;
        while (cap_frames == start && t < FRAME_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (cap_frames == start) begin
            $display("timeout: no I2S frame captured");
            errors++;
        end
    endtask

    task automatic wait_flip(output int frames);
        logic sign0;
        sign0  = cap_left[15];
        frames = 0;
        while (cap_left[15] == sign0 && frames < FLIP_LIMIT) begin
            wait_frame();
            frames++;
        end
        if (cap_left[15] == sign0) begin
            $display("timeout: captured left sample never changed sign");
            errors++;
        end
    endtask

    // frames between two sign flips, after the pipeline has settled
    task automatic measure_run(output int len);
        int skipped;
        repeat (4) wait_frame();
        wait_flip(skipped);
        wait_flip(len);
    endtask

    task automatic wait_digit(input int idx);
        int t;
        logic [3:0] want;
        want = ~(4'b0001 << idx);
        t = 0;
        while (digit_o !== want && t < DIGIT_LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (digit_o !== want) begin
            $display("timeout: display never selected digit %0d", idx);
            errors++;
        end
    endtask

    initial begin
        logic [15:0] vol;
        logic [15:0] rd;
        int len;
        rst         = 1'b1;
        scan_req_i  = 1'b0;
        scan_data_i = 8'h00;
        cfg_req_i   = 1'b0;
        cfg_we_i    = 1'b0;
        cfg_addr_i  = audio_pkg::REG_VOLUME;
        cfg_wdata_i = '0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        start_test("init_gate");
        send_byte(8'h1C);
        check_eq("events before init", 32'd0, 32'(ev_cnt));
        send_byte(kbd_pkg::SC_INIT);
        check_eq("events after init byte", 32'd0, 32'(ev_cnt));
        send_byte(8'h1C);
        check_eq("event count", 32'd1, 32'(ev_cnt));
        check_eq("key code", 32'h01C, 32'(ev_code));
        check_eq("break flag", 32'd0, 32'(ev_break));
        finish_test();

        start_test("prefixes");
        send_byte(kbd_pkg::SC_EXTEND);
        send_byte(8'h75);
        check_eq("extended event count", 32'd2, 32'(ev_cnt));
        check_eq("extended code", 32'h175, 32'(ev_code));
        check_eq("extended break", 32'd0, 32'(ev_break));
        send_byte(8'h15);
        check_eq("plain code after extend", 32'h015, 32'(ev_code));
        send_byte(kbd_pkg::SC_BREAK);
        send_byte(8'h1C);
        check_eq("break code", 32'h01C, 32'(ev_code));
        check_eq("break flag", 32'd1, 32'(ev_break));
        send_byte(8'h15);
        check_eq("plain break after break", 32'd0, 32'(ev_break));
        check_eq("total events", 32'd5, 32'(ev_cnt));
        finish_test();

        start_test("tone_volume");
        vol = 16'(($random(seed) & 32'h3FFF) | 32'h0100); // nonzero, below full scale
        cfg_write(audio_pkg::REG_VOLUME, vol);
        cfg_read(audio_pkg::REG_VOLUME, rd);
        check_eq("volume readback", 32'(vol), 32'(rd));
        cfg_write(audio_pkg::REG_CTRL, 16'h0000);
        cfg_read(audio_pkg::REG_CTRL, rd);
        check_eq("ctrl readback", 32'h0, 32'(rd));
        send_byte(8'h1C);
        repeat (4) wait_frame();
        check_eq("held magnitude", 32'(vol), 32'(magnitude(cap_left)));
        wait_flip(len);
        check_eq("magnitude after flip", 32'(vol), 32'(magnitude(cap_left)));
        send_byte(kbd_pkg::SC_BREAK);
        send_byte(8'h1C);
        repeat (4) wait_frame();
        check_eq("released sample", 32'h0, 32'(cap_left));
        finish_test();

        start_test("note_priority");
        send_byte(8'h1B);
        send_byte(8'h1C);
        measure_run(len);
        check_eq("half period", 32'(half_tab[0]), 32'(len));
        cfg_write(audio_pkg::REG_CTRL, 16'h0002); // octave 1, unmuted
        measure_run(len);
        check_eq("half period octave 1", 32'(half_tab[0] >> 1), 32'(len));
        finish_test();

        start_test("mute_stereo");
        check_eq("right equals left", 32'(cap_right_left), 32'(cap_right));
        check_eq("right magnitude", 32'(vol), 32'(magnitude(cap_right)));
        cfg_write(audio_pkg::REG_CTRL, 16'h0003);
        repeat (4) wait_frame();
        check_eq("muted sample", 32'h0, 32'(cap_left));
        check_eq("muted right", 32'h0, 32'(cap_right));
        send_byte(kbd_pkg::SC_BREAK);
        send_byte(8'h1C);
        send_byte(kbd_pkg::SC_BREAK);
        send_byte(8'h1B);
        finish_test();

        start_test("display");
        wait_digit(0);
        check_eq("digit 0 after break", 32'(SEG_B), 32'(seg_o));
        wait_digit(3);
        check_eq("digit 3 after break", 32'(SEG_DASH), 32'(seg_o));
        send_byte(8'h15);
        wait_digit(0);
        check_eq("digit 0 after make", 32'(SEG_5), 32'(seg_o));
        wait_digit(3);
        check_eq("digit 3 after make", 32'(SEG_BLANK), 32'(seg_o));
        finish_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* vlog.f */
hdl/kbd_pkg.sv
hdl/audio_pkg.sv
hdl/scan_decoder.sv
hdl/tone_regs.sv
hdl/tone_gen.sv
hdl/i2s_serializer.sv
hdl/seg_display.sv
hdl/key_tone_top.sv
bench/tb_key_tone.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_key_tone
FILELIST = vlog.f
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF "=== PASS ==="

clean:
	rm -rf $(BUILD)
